/* verilog/scan_params.svh */
`ifndef SCAN_PARAMS_SVH
`define SCAN_PARAMS_SVH

// Bits per colour channel at the input
`define VID_COLORW      4

// Bits per colour channel at the display side
`define VID_OUTW        8

// Active pixels in one line
`define VID_LINE_LEN    16

// Line banks in the store, also the credits held by the writer at reset
`define VID_LINE_BANKS  2

`endif

/* verilog/video_pkg.sv */
`include "scan_params.svh"

package video_pkg;

    // Native pixel as produced by the video core
    typedef struct packed {
        logic [`VID_COLORW-1:0] r;
        logic [`VID_COLORW-1:0] g;
        logic [`VID_COLORW-1:0] b;
    } rgb_pix_t;

    // Pixel after widening, as sent to the display
    typedef struct packed {
        logic [`VID_OUTW-1:0] r;
        logic [`VID_OUTW-1:0] g;
        logic [`VID_OUTW-1:0] b;
    } rgb8_pix_t;

    // One write into the line store
    typedef struct packed {
        logic       we;
        logic       bank;
        logic [3:0] idx;
        rgb_pix_t   pix;
        logic       last;   // closes the line and marks the bank full
    } line_wr_t;

endpackage

/* verilog/scan_ctrl_pkg.sv */
`include "scan_params.svh"

package scan_ctrl_pkg;

    // Dimming applied to the repeated copy of each line
    typedef enum logic [1:0] {
        SL_NONE = 2'd0,
        SL_25   = 2'd1,
        SL_50   = 2'd2,
        SL_75   = 2'd3
    } sl_mode_e;

    // Replay FSM
    typedef enum logic [1:0] {
        RP_IDLE  = 2'd0,
        RP_PASS0 = 2'd1,
        RP_PASS1 = 2'd2
    } replay_state_e;

    // Enough to hold every bank as a credit
    typedef logic [$clog2(`VID_LINE_BANKS+1)-1:0] credit_t;

endpackage

/* verilog/line_capture.sv */
`timescale 1ns/1ns
`include "scan_params.svh"

module line_capture import video_pkg::*, scan_ctrl_pkg::*; (
    input  logic     clk_sys,
    input  logic     rst_n,
    input  logic     in_valid,
    input  logic     in_first,
    input  rgb_pix_t in_pix,
    input  logic     bw_en,
    input  logic     credit_ret,
    output logic     in_ready,
    output line_wr_t wr
);

localparam logic [3:0] LAST_IDX = 4'(`VID_LINE_LEN - 1);

credit_t    credits;
logic       in_line;
logic [3:0] pix_idx;
logic       wr_bank;
logic       bw_on;
rgb_pix_t   prev_pix;
rgb_pix_t   filt_pix;
logic       take;
logic       line_start;
logic       line_end;

logic       wr_we;
logic       wr_bank_q;
logic [3:0] wr_idx_q;
rgb_pix_t   wr_pix_q;
logic       wr_last_q;

// Truncated mean of two samples
function automatic logic [`VID_COLORW-1:0] avg2(
    input logic [`VID_COLORW-1:0] a,
    input logic [`VID_COLORW-1:0] b
);
    logic [`VID_COLORW:0] sum;
    sum = a + b;
    return sum[`VID_COLORW:1];
endfunction

// A line may only open while a bank credit is held
assign in_ready = (credits != '0) || in_line;

// Pixels outside a line without in_first are dropped until resync
assign take       = in_valid && in_ready && (in_line || in_first);
assign line_start = take && !in_line;
assign line_end   = take && (pix_idx == LAST_IDX);

// Wire bandwidth filter, first pixel of a line passes untouched
always_comb begin
    filt_pix = in_pix;
    if (in_line && bw_on) begin
        filt_pix.r = avg2(in_pix.r, prev_pix.r);
        filt_pix.g = avg2(in_pix.g, prev_pix.g);
        filt_pix.b = avg2(in_pix.b, prev_pix.b);
    end
end

always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
        credits <= credit_t'(`VID_LINE_BANKS);
        in_line <= 1'b0;
        pix_idx <= '0;
        wr_bank <= 1'b0;
        bw_on   <= 1'b0;
        wr_we   <= 1'b0;
    end else begin
        credits <= credits - credit_t'(line_start) + credit_t'(credit_ret);
        wr_we   <= take;
        if (line_start) begin
            bw_on <= bw_en;
        end
        if (take) begin
            if (line_end) begin
                in_line <= 1'b0;
                pix_idx <= '0;
                wr_bank <= ~wr_bank;
            end else begin
                in_line <= 1'b1;
                pix_idx <= pix_idx + 4'd1;
            end
        end
    end
end

always_ff @(posedge clk_sys) begin
    if (take) begin
        prev_pix  <= in_pix;
        wr_bank_q <= wr_bank;
        wr_idx_q  <= pix_idx;
        wr_pix_q  <= filt_pix;
        wr_last_q <= line_end;
    end
end

assign wr = '{we: wr_we, bank: wr_bank_q, idx: wr_idx_q, pix: wr_pix_q, last: wr_last_q};

endmodule

/* verilog/line_store.sv */
`timescale 1ns/1ns
`include "scan_params.svh"

module line_store import video_pkg::*; (
    input  logic       clk_sys,
    input  logic       rst_n,
    input  line_wr_t   wr,
    input  logic       rd_bank,
    input  logic [3:0] rd_idx,
    input  logic       release_vld,
    input  logic       release_bank,
    output rgb_pix_t   rd_pix,
    output logic [1:0] line_full,
    output logic       credit_ret
);

localparam int DEPTH = `VID_LINE_BANKS * `VID_LINE_LEN;

// Bank index is the top address bit
rgb_pix_t mem [DEPTH];

logic [4:0] wr_addr;
logic [4:0] rd_addr;

assign wr_addr = {wr.bank, wr.idx};
assign rd_addr = {rd_bank, rd_idx};

always_ff @(posedge clk_sys) begin
    if (wr.we) begin
        mem[wr_addr] <= wr.pix;
    end
end

// Registered read, data one cycle after the address
always_ff @(posedge clk_sys) begin
    rd_pix <= mem[rd_addr];
end

// Full flags and credit return
always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
        line_full  <= '0;
        credit_ret <= 1'b0;
    end else begin
        credit_ret <= release_vld;
        if (release_vld) begin
            line_full[release_bank] <= 1'b0;
        end
        // Commit of the last pixel
        if (wr.we && wr.last) begin
            line_full[wr.bank] <= 1'b1;
        end
    end
end

endmodule

/* verilog/line_replay.sv */
`timescale 1ns/1ns
`include "scan_params.svh"

module line_replay import video_pkg::*, scan_ctrl_pkg::*; (
    input  logic       clk_sys,
    input  logic       rst_n,
    input  logic [1:0] line_full,
    input  rgb_pix_t   rd_pix,
    input  sl_mode_e   sl_mode,
    output logic       rd_bank,
    output logic [3:0] rd_idx,
    output logic       release_vld,
    output logic       release_bank,
    output logic       out_valid,
    output logic       out_line_start,
    output rgb8_pix_t  out_pix
);

localparam logic [3:0] LAST_IDX = 4'(`VID_LINE_LEN - 1);

replay_state_e state;
logic          cur_bank;
logic [3:0]    ptr;
sl_mode_e      sl_q;
logic          copy1_q;
logic          last_q;
logic          at_end;

// Bit repetition up to the display width
function automatic logic [`VID_OUTW-1:0] widen(input logic [`VID_COLORW-1:0] c);
    return {(`VID_OUTW / `VID_COLORW){c}};
endfunction

// Scanline dimming of one channel
function automatic logic [`VID_OUTW-1:0] shade(
    input logic [`VID_OUTW-1:0] v,
    input logic                 dim,
    input sl_mode_e             mode
);
    logic [`VID_OUTW-1:0] res;
    res = v;
    if (dim) begin
        case (mode)
            SL_25:   res = v - (v >> 2);
            SL_50:   res = v >> 1;
            SL_75:   res = v >> 2;
            default: res = v;
        endcase
    end
    return res;
endfunction

assign at_end  = (ptr == LAST_IDX);
assign rd_bank = cur_bank;
assign rd_idx  = ptr;

// cur_bank has already moved on by the time the release goes out
assign release_bank = ~cur_bank;

always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
        state    <= RP_IDLE;
        cur_bank <= 1'b0;
        ptr      <= '0;
        sl_q     <= SL_NONE;
    end else begin
        case (state)
            RP_IDLE: begin
                if (line_full[cur_bank]) begin
                    state <= RP_PASS0;
                    ptr   <= '0;
                    sl_q  <= sl_mode;
                end
            end
            RP_PASS0: begin
                if (at_end) begin
                    ptr   <= '0;
                    state <= RP_PASS1;
                end else begin
                    ptr <= ptr + 4'd1;
                end
            end
            RP_PASS1: begin
                if (at_end) begin
                    ptr      <= '0;
                    cur_bank <= ~cur_bank;
                    state    <= RP_IDLE;
                end else begin
                    ptr <= ptr + 4'd1;
                end
            end
            default: state <= RP_IDLE;
        endcase
    end
end

// Control follows the read address by one cycle, in step with rd_pix
always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
        out_valid      <= 1'b0;
        out_line_start <= 1'b0;
        copy1_q        <= 1'b0;
        last_q         <= 1'b0;
        release_vld    <= 1'b0;
    end else begin
        out_valid      <= (state != RP_IDLE);
        out_line_start <= (state != RP_IDLE) && (ptr == '0);
        copy1_q        <= (state == RP_PASS1);
        last_q         <= (state == RP_PASS1) && at_end;
        // Bank handed back once its last pixel is out
        release_vld    <= last_q;
    end
end

always_comb begin
    out_pix.r = shade(widen(rd_pix.r), copy1_q, sl_q);
    out_pix.g = shade(widen(rd_pix.g), copy1_q, sl_q);
    out_pix.b = shade(widen(rd_pix.b), copy1_q, sl_q);
end

endmodule

/* verilog/scan2x_top.sv */
`timescale 1ns/1ns

module scan2x_top import video_pkg::*, scan_ctrl_pkg::*; (
    input  logic      clk_sys,
    input  logic      rst_n,
    input  logic      in_valid,
    input  logic      in_first,
    input  rgb_pix_t  in_pix,
    input  logic      bw_en,
    input  sl_mode_e  sl_mode,
    output logic      in_ready,
    output logic      out_valid,
    output logic      out_line_start,
    output rgb8_pix_t out_pix
);

line_wr_t   wr;
rgb_pix_t   rd_pix;
logic       rd_bank;
logic [3:0] rd_idx;
logic       release_vld;
logic       release_bank;
logic [1:0] line_full;
logic       credit_ret;

// Producer side
line_capture u_capture (
    .clk_sys        ( clk_sys        ),
    .rst_n          ( rst_n          ),
    .in_valid       ( in_valid       ),
    .in_first       ( in_first       ),
    .in_pix         ( in_pix         ),
    .bw_en          ( bw_en          ),
    .credit_ret     ( credit_ret     ),
    .in_ready       ( in_ready       ),
    .wr             ( wr             )
);

line_store u_store (
    .clk_sys        ( clk_sys        ),
    .rst_n          ( rst_n          ),
    .wr             ( wr             ),
    .rd_bank        ( rd_bank        ),
    .rd_idx         ( rd_idx         ),
    .release_vld    ( release_vld    ),
    .release_bank   ( release_bank   ),
    .rd_pix         ( rd_pix         ),
    .line_full      ( line_full      ),
    .credit_ret     ( credit_ret     )
);

// Display side, never stalls
line_replay u_replay (
    .clk_sys        ( clk_sys        ),
    .rst_n          ( rst_n          ),
    .line_full      ( line_full      ),
    .rd_pix         ( rd_pix         ),
    .sl_mode        ( sl_mode        ),
    .rd_bank        ( rd_bank        ),
    .rd_idx         ( rd_idx         ),
    .release_vld    ( release_vld    ),
    .release_bank   ( release_bank   ),
    .out_valid      ( out_valid      ),
    .out_line_start ( out_line_start ),
    .out_pix        ( out_pix        )
);

endmodule

/* tb/tb_scan2x.sv */
`timescale 1ns/1ns
`include "scan_params.svh"

module tb_scan2x import video_pkg::*, scan_ctrl_pkg::*;;

localparam int MAX_GAP   = 8;
localparam int NUM_LINES = 36;
localparam int CYCLE_LIMIT = NUM_LINES * (8 * `VID_LINE_LEN + MAX_GAP) + 200;

logic      clk_sys;
logic      rst_n;
logic      in_valid;
logic      in_first;
rgb_pix_t  in_pix;
logic      bw_en;
sl_mode_e  sl_mode;
logic      in_ready;
logic      out_valid;
logic      out_line_start;
rgb8_pix_t out_pix;

integer      seed;
int          cycles;
logic        saw_stall;
logic [24:0] exp_item;
logic [24:0] exp_q [$];
rgb_pix_t    line_buf [`VID_LINE_LEN];

scan2x_top dut0 (
    .clk_sys        ( clk_sys        ),
    .rst_n          ( rst_n          ),
    .in_valid       ( in_valid       ),
    .in_first       ( in_first       ),
    .in_pix         ( in_pix         ),
    .bw_en          ( bw_en          ),
    .sl_mode        ( sl_mode        ),
    .in_ready       ( in_ready       ),
    .out_valid      ( out_valid      ),
    .out_line_start ( out_line_start ),
    .out_pix        ( out_pix        )
);

always #20 clk_sys = ~clk_sys;

task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
endtask

task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
        $display("ERR %0t: %s mismatch, got %h, expected %h", $time, what, actual, expected);
        abort_run();
    end
endtask

// Reference rules for one channel
function automatic logic [`VID_COLORW-1:0] avg_chan(input logic [`VID_COLORW-1:0] a,
                                                    input logic [`VID_COLORW-1:0] b);
    int s;
    s = (int'(a) + int'(b)) / 2;
    return s[`VID_COLORW-1:0];
endfunction

function automatic logic [`VID_OUTW-1:0] widen_chan(input logic [`VID_COLORW-1:0] c);
    logic [`VID_OUTW-1:0] w;
    int k;
    for (k = 0; k < `VID_OUTW; k++) begin
        w[`VID_OUTW-1-k] = c[`VID_COLORW-1-(k % `VID_COLORW)];
    end
    return w;
endfunction

function automatic logic [`VID_OUTW-1:0] dim_chan(input logic [`VID_OUTW-1:0] v,
                                                  input sl_mode_e mode);
    int x;
    x = int'(v);
    case (mode)
        SL_25:   x = x - x / 4;
        SL_50:   x = x / 2;
        SL_75:   x = x / 4;
        default: x = int'(v);
    endcase
    return x[`VID_OUTW-1:0];
endfunction

// Both copies of the line in line_buf go into the expected queue
task automatic push_line(input logic bw_line);
    rgb_pix_t  f;
    rgb8_pix_t w;
    int        i;
    int        c;
    for (c = 0; c < 2; c++) begin
        for (i = 0; i < `VID_LINE_LEN; i++) begin
            f = line_buf[i];
            if (bw_line && i > 0) begin
                f.r = avg_chan(line_buf[i].r, line_buf[i-1].r);
                f.g = avg_chan(line_buf[i].g, line_buf[i-1].g);
                f.b = avg_chan(line_buf[i].b, line_buf[i-1].b);
            end
            w.r = widen_chan(f.r);
            w.g = widen_chan(f.g);
            w.b = widen_chan(f.b);
            if (c == 1) begin
                w.r = dim_chan(w.r, sl_mode);
                w.g = dim_chan(w.g, sl_mode);
                w.b = dim_chan(w.b, sl_mode);
            end
            exp_q.push_back({(i == 0), w});
        end
    end
endtask

// Entered and left 2 ns after a rising edge
task automatic send_line(input logic use_gaps);
    logic [31:0] rnd;
    int          gap;
    int          idx;
    logic        bw_line;
    rnd = $random(seed);
    gap = use_gaps ? ({rnd} % (MAX_GAP + 1)) : 0;
    repeat (gap) begin
        @(posedge clk_sys);
        #2;
    end
    for (idx = 0; idx < `VID_LINE_LEN; idx++) begin
        rnd = $random(seed);
        line_buf[idx] = rnd[$bits(rgb_pix_t)-1:0];
    end
    bw_line = bw_en;
    idx = 0;
    while (idx < `VID_LINE_LEN) begin
        rnd = $random(seed);
        if (use_gaps && rnd[2:0] == 3'd0) begin
            in_valid = 1'b0;
            in_first = 1'b0;
            in_pix   = rnd[$bits(rgb_pix_t)+2:3];
        end else begin
            in_valid = 1'b1;
            in_first = (idx == 0);
            in_pix   = line_buf[idx];
        end
        @(negedge clk_sys);
        if (in_valid && !in_ready) begin
            saw_stall = 1'b1;
        end
        if (in_valid && in_ready) begin
            idx++;
        end
        @(posedge clk_sys);
        #2;
    end
    in_valid = 1'b0;
    in_first = 1'b0;
    push_line(bw_line);
endtask

task automatic wait_drain();
    while (exp_q.size() != 0) begin
        @(negedge clk_sys);
    end
    repeat (2) @(posedge clk_sys);
    #2;
endtask

// Output checker, samples mid-cycle
always @(negedge clk_sys) begin
    if (rst_n && out_valid) begin
        if (exp_q.size() == 0) begin
            $display("Output pixel appeared at %0t while no pixel was expected", $time);
            abort_run();
        end else begin
            exp_item = exp_q.pop_front();
            compare(32'(out_line_start), 32'(exp_item[24]), "out_line_start");
            compare(32'(out_pix), 32'(exp_item[23:0]), "out_pix");
        end
    end else if (rst_n) begin
        // Line start only ever marks a valid pixel
        compare(32'(out_line_start), 32'd0, "out_line_start without out_valid");
    end
end

always @(posedge clk_sys) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
        $display("Timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
        abort_run();
    end
end

initial begin
    logic [31:0] rnd;
    seed       = 51711;
    cycles     = 0;
    saw_stall  = 1'b0;
    clk_sys    = 1'b0;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_first   = 1'b0;
    in_pix     = '0;
    bw_en      = 1'b0;
    sl_mode    = SL_NONE;
    repeat (10) @(posedge clk_sys);
    #2;
    rst_n = 1'b1;
    @(posedge clk_sys);
    #2;
    // Idle state after reset
    compare(32'(out_valid), 32'd0, "out_valid after reset");
    compare(32'(in_ready), 32'd1, "in_ready after reset");
    // Plain doubling
    repeat (6) send_line(1'b0);
    wait_drain();
    // Bandwidth filter
    bw_en = 1'b1;
    repeat (6) send_line(1'b0);
    wait_drain();
    // Scanline modes
    bw_en = 1'b0;
    sl_mode = SL_25;
    repeat (4) send_line(1'b0);
    wait_drain();
    sl_mode = SL_50;
    repeat (4) send_line(1'b0);
    wait_drain();
    sl_mode = SL_75;
    repeat (4) send_line(1'b0);
    wait_drain();
    // Random gaps with mixed filter setting
    saw_stall = 1'b0;
    sl_mode = SL_50;
    repeat (12) begin
        rnd = $random(seed);
        bw_en = rnd[0];
        send_line(1'b1);
    end
    wait_drain();
    compare(32'(saw_stall), 32'd1, "in_ready back-pressure seen");
    $display("SIMULATION PASSED");
    $finish;
end

endmodule

/* files.f */
+incdir+verilog
verilog/video_pkg.sv
verilog/scan_ctrl_pkg.sv
verilog/line_capture.sv
verilog/line_store.sv
verilog/line_replay.sv
verilog/scan2x_top.sv
tb/tb_scan2x.sv
